//--- design/hole_edge_mover.sv
`timescale 1ns/1ns

module hole_edge_mover #(
    parameter logic [25:0] MOVE_TICKS = 26'd3_200_000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  obstacle_pkg::phase_t  phase,
    input  logic                  load_edges,
    output obstacle_pkg::coord_t  hole_top,
    output obstacle_pkg::coord_t  hole_bottom,
    output obstacle_pkg::coord_t  hole_left,
    output obstacle_pkg::coord_t  hole_right,
    output logic                  at_target
);

    localparam logic [25:0] FAST_TICKS = MOVE_TICKS / 2;

    // what one edge does on a step
    typedef enum logic [1:0] {
        EDGE_HOLD,
        EDGE_INC,
        EDGE_DEC
    } edge_step_t;

    edge_step_t  top_step;
    edge_step_t  bottom_step;
    edge_step_t  left_step;
    edge_step_t  right_step;
    logic [25:0] step_timer;
    logic [25:0] step_period;
    logic        moving;

    function automatic obstacle_pkg::coord_t stepped(input obstacle_pkg::coord_t edge_pos,
                                                     input edge_step_t           step);
        case (step)
            EDGE_INC: return edge_pos + 12'd1;  // down or right
            EDGE_DEC: return edge_pos - 12'd1;  // up or left
            default:  return edge_pos;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // per-phase moves, rate and end condition
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        top_step    = EDGE_HOLD;
        bottom_step = EDGE_HOLD;
        left_step   = EDGE_HOLD;
        right_step  = EDGE_HOLD;
        at_target   = 1'b0;
        step_period = MOVE_TICKS;
        case (phase)
            obstacle_pkg::CLOSE_IN: begin           // shrink from all sides
                top_step    = EDGE_INC;
                bottom_step = EDGE_DEC;
                left_step   = EDGE_INC;
                right_step  = EDGE_DEC;
                at_target   = hole_top >= obstacle_pkg::CLOSE_IN_TARGET;
            end
            obstacle_pkg::SHIFT_RIGHT_UP: begin
                top_step    = EDGE_DEC;
                bottom_step = EDGE_DEC;
                left_step   = EDGE_INC;
                right_step  = EDGE_INC;
                at_target   = hole_right >= obstacle_pkg::FIELD_RIGHT;
            end
            obstacle_pkg::SHIFT_DOWN: begin
                top_step    = EDGE_INC;
                bottom_step = EDGE_INC;
                at_target   = hole_bottom >= obstacle_pkg::FIELD_BOTTOM;
            end
            obstacle_pkg::SHIFT_LEFT_UP: begin
                top_step    = EDGE_DEC;
                bottom_step = EDGE_DEC;
                left_step   = EDGE_DEC;
                right_step  = EDGE_DEC;
                at_target   = hole_top <= obstacle_pkg::FIELD_TOP;
                step_period = FAST_TICKS;
            end
            obstacle_pkg::NARROW: begin             // hole gets smaller toward top left
                bottom_step = EDGE_DEC;
                right_step  = EDGE_DEC;
                at_target   = hole_right <= obstacle_pkg::NARROW_TARGET;
            end
            obstacle_pkg::SHIFT_DOWN_MIDDLE: begin
                top_step    = EDGE_INC;
                bottom_step = EDGE_INC;
                at_target   = hole_top >= obstacle_pkg::MIDDLE_TARGET;
                step_period = FAST_TICKS;
            end
            obstacle_pkg::SHIFT_TO_CENTER: begin
                left_step   = EDGE_INC;
                right_step  = EDGE_INC;
                at_target   = hole_left >= obstacle_pkg::CENTER_TARGET;
                step_period = FAST_TICKS;
            end
            default: ;                              // idle, nothing moves
        endcase
    end

    assign moving = (phase != obstacle_pkg::IDLE) && !at_target;

    ////////////////////////////////////////////////////////////////////////////
    // edge registers and step timer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hole_top    <= '0;
            hole_bottom <= '0;
            hole_left   <= '0;
            hole_right  <= '0;
            step_timer  <= '0;
        end else if (load_edges) begin
            // hole starts one pixel inside the field
            hole_top    <= obstacle_pkg::FIELD_TOP + 12'd1;
            hole_bottom <= obstacle_pkg::FIELD_BOTTOM - 12'd1;
            hole_left   <= obstacle_pkg::FIELD_LEFT + 12'd1;
            hole_right  <= obstacle_pkg::FIELD_RIGHT - 12'd1;
            step_timer  <= '0;
        end else if (moving) begin
            if (step_timer >= step_period) begin
                hole_top    <= stepped(hole_top, top_step);
                hole_bottom <= stepped(hole_bottom, bottom_step);
                hole_left   <= stepped(hole_left, left_step);
                hole_right  <= stepped(hole_right, right_step);
                step_timer  <= '0;
            end else begin
                step_timer <= step_timer + 26'd1;
            end
        end else begin
            step_timer <= '0;   // parked on target or idle
        end
    end

    // the sequence never pushes the hole outside the playing area
    a_edges_in_field: assert property (
        @(posedge clk) disable iff (rst)
        (phase != obstacle_pkg::IDLE) |->
            (hole_top >= obstacle_pkg::FIELD_TOP) && (hole_top <= obstacle_pkg::FIELD_BOTTOM) &&
            (hole_bottom >= obstacle_pkg::FIELD_TOP) &&
            (hole_bottom <= obstacle_pkg::FIELD_BOTTOM) &&
            (hole_left >= obstacle_pkg::FIELD_LEFT) &&
            (hole_left <= obstacle_pkg::FIELD_RIGHT) &&
            (hole_right >= obstacle_pkg::FIELD_LEFT) &&
            (hole_right <= obstacle_pkg::FIELD_RIGHT)
    );

endmodule

//--- design/hole_sequencer.sv
`timescale 1ns/1ns

module hole_sequencer #(
    parameter logic [2:0]  SELECT_CODE = 3'd3,
    parameter logic [25:0] DWELL_TICKS = 26'd32_000_000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 menu_on,
    input  logic                 play_selected,
    input  logic [2:0]           selected,
    input  logic                 done_in,
    input  logic                 at_target,
    output obstacle_pkg::phase_t phase,
    output logic                 load_edges,
    output logic                 done
);

    logic [25:0]          dwell_cnt;    // cycles spent parked on the target
    obstacle_pkg::phase_t phase_after;  // successor in the fixed program
    logic                 start_ok;
    logic                 abort;
    logic                 dwell_over;

    ////////////////////////////////////////////////////////////////////////////
    // start, abort and dwell conditions
    ////////////////////////////////////////////////////////////////////////////

    assign start_ok   = done_in && (selected == SELECT_CODE) && play_selected;
    assign load_edges = (phase == obstacle_pkg::IDLE) && start_ok;

    // leaving the game screen kills the run quietly
    assign abort = (phase != obstacle_pkg::IDLE) && (menu_on || !play_selected);

    assign dwell_over = at_target && (dwell_cnt == DWELL_TICKS);

    always_comb begin
        case (phase)
            obstacle_pkg::CLOSE_IN:          phase_after = obstacle_pkg::SHIFT_RIGHT_UP;
            obstacle_pkg::SHIFT_RIGHT_UP:    phase_after = obstacle_pkg::SHIFT_DOWN;
            obstacle_pkg::SHIFT_DOWN:        phase_after = obstacle_pkg::SHIFT_LEFT_UP;
            obstacle_pkg::SHIFT_LEFT_UP:     phase_after = obstacle_pkg::NARROW;
            obstacle_pkg::NARROW:            phase_after = obstacle_pkg::SHIFT_DOWN_MIDDLE;
            obstacle_pkg::SHIFT_DOWN_MIDDLE: phase_after = obstacle_pkg::SHIFT_TO_CENTER;
            default:                         phase_after = obstacle_pkg::IDLE; // end of program
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase register and dwell counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= obstacle_pkg::IDLE;
            dwell_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load_edges) begin
                phase     <= obstacle_pkg::CLOSE_IN;
                dwell_cnt <= '0;
            end else if (abort) begin
                phase     <= obstacle_pkg::IDLE;    // no done on abort
                dwell_cnt <= '0;
            end else if ((phase != obstacle_pkg::IDLE) && at_target) begin
                if (dwell_over) begin
                    phase     <= phase_after;
                    dwell_cnt <= '0;                // every dwell starts fresh
                    done      <= (phase == obstacle_pkg::SHIFT_TO_CENTER);
                end else begin
                    dwell_cnt <= dwell_cnt + 26'd1;
                end
            end else begin
                dwell_cnt <= '0;                    // still moving
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // done only comes out of the last phase
    a_done_after_last: assert property (
        @(posedge clk) disable iff (rst)
        done |-> $past(phase) == obstacle_pkg::SHIFT_TO_CENTER
    );

    // a start opens a fresh hole that is still short of the first target
    a_load_fresh_hole: assert property (
        @(posedge clk) disable iff (rst)
        load_edges |=> (phase == obstacle_pkg::CLOSE_IN) && !at_target
    );

endmodule

//--- design/obstacle_pkg.sv
package obstacle_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [11:0] coord_t;   // pixel coordinate, also used for hole edges
    typedef logic [11:0] rgb_t;     // 4 bits per channel, r g b

    // obstacle program, in the order it runs
    typedef enum logic [2:0] {
        IDLE,
        CLOSE_IN,
        SHIFT_RIGHT_UP,
        SHIFT_DOWN,
        SHIFT_LEFT_UP,
        NARROW,
        SHIFT_DOWN_MIDDLE,
        SHIFT_TO_CENTER
    } phase_t;

    ////////////////////////////////////////////////////////////////////////////
    // game field geometry
    ////////////////////////////////////////////////////////////////////////////

    // inclusive borders of the playing area
    localparam coord_t FIELD_TOP    = 12'd317;
    localparam coord_t FIELD_BOTTOM = 12'd617;
    localparam coord_t FIELD_LEFT   = 12'd361;
    localparam coord_t FIELD_RIGHT  = 12'd661;

    localparam rgb_t WALL_RGB = 12'hfff;    // white

    // phase end points, the remaining phases stop on a field border
    localparam coord_t CLOSE_IN_TARGET = FIELD_TOP + 12'd125;   // top edge
    localparam coord_t NARROW_TARGET   = FIELD_LEFT + 12'd40;   // right edge
    localparam coord_t MIDDLE_TARGET   = FIELD_TOP + 12'd130;   // top edge
    localparam coord_t CENTER_TARGET   = FIELD_LEFT + 12'd130;  // left edge

endpackage

//--- design/square_hole_obstacle.sv
`timescale 1ns/1ns

module square_hole_obstacle #(
    parameter logic [2:0]  SELECT_CODE = 3'd3,
    parameter logic [25:0] MOVE_TICKS  = 26'd3_200_000,
    parameter logic [25:0] DWELL_TICKS = 26'd32_000_000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  obstacle_pkg::coord_t hcount,
    input  obstacle_pkg::coord_t vcount,
    input  obstacle_pkg::rgb_t   rgb_in,
    input  logic                 menu_on,
    input  logic                 play_selected,
    input  logic [2:0]           selected,
    input  logic                 done_in,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::coord_t obstacle_x,
    output obstacle_pkg::coord_t obstacle_y,
    output logic                 done
);

    obstacle_pkg::phase_t phase;
    logic                 load_edges;
    logic                 at_target;
    obstacle_pkg::coord_t hole_top;
    obstacle_pkg::coord_t hole_bottom;
    obstacle_pkg::coord_t hole_left;
    obstacle_pkg::coord_t hole_right;

    hole_sequencer #(
        .SELECT_CODE (SELECT_CODE),
        .DWELL_TICKS (DWELL_TICKS)
    ) u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .menu_on       (menu_on),
        .play_selected (play_selected),
        .selected      (selected),
        .done_in       (done_in),
        .at_target     (at_target),
        .phase         (phase),
        .load_edges    (load_edges),
        .done          (done)
    );

    hole_edge_mover #(
        .MOVE_TICKS (MOVE_TICKS)
    ) u_mover (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .load_edges  (load_edges),
        .hole_top    (hole_top),
        .hole_bottom (hole_bottom),
        .hole_left   (hole_left),
        .hole_right  (hole_right),
        .at_target   (at_target)
    );

    wall_painter u_painter (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .hcount      (hcount),
        .vcount      (vcount),
        .hole_top    (hole_top),
        .hole_bottom (hole_bottom),
        .hole_left   (hole_left),
        .hole_right  (hole_right),
        .rgb_in      (rgb_in),
        .rgb_out     (rgb_out),
        .obstacle_x  (obstacle_x),
        .obstacle_y  (obstacle_y)
    );

endmodule

//--- design/wall_painter.sv
`timescale 1ns/1ns

module wall_painter (
    input  logic                 clk,
    input  logic                 rst,
    input  obstacle_pkg::phase_t phase,
    input  obstacle_pkg::coord_t hcount,
    input  obstacle_pkg::coord_t vcount,
    input  obstacle_pkg::coord_t hole_top,
    input  obstacle_pkg::coord_t hole_bottom,
    input  obstacle_pkg::coord_t hole_left,
    input  obstacle_pkg::coord_t hole_right,
    input  obstacle_pkg::rgb_t   rgb_in,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::coord_t obstacle_x,
    output obstacle_pkg::coord_t obstacle_y
);

    logic in_field;
    logic beyond_edge;
    logic wall_px;

    ////////////////////////////////////////////////////////////////////////////
    // pixel test
    ////////////////////////////////////////////////////////////////////////////

    assign in_field = (hcount >= obstacle_pkg::FIELD_LEFT) &&
                      (hcount <= obstacle_pkg::FIELD_RIGHT) &&
                      (vcount >= obstacle_pkg::FIELD_TOP) &&
                      (vcount <= obstacle_pkg::FIELD_BOTTOM);

    // edges themselves belong to the wall
    assign beyond_edge = (vcount <= hole_top) || (vcount >= hole_bottom) ||
                         (hcount >= hole_right) || (hcount <= hole_left);

    assign wall_px = (phase != obstacle_pkg::IDLE) && in_field && beyond_edge;

    ////////////////////////////////////////////////////////////////////////////
    // output stage, one cycle behind the scan
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out    <= '0;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end else if (wall_px) begin
            rgb_out    <= obstacle_pkg::WALL_RGB;
            obstacle_x <= hcount;   // report the pixel we hit
            obstacle_y <= vcount;
        end else begin
            rgb_out    <= rgb_in;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end
    end

endmodule

//--- dv/obstacle_tests.svh
////////////////////////////////////////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////////////////////////////////////////

localparam int CENTRE_X = 511;
localparam int CENTRE_Y = 467;

// close-in geometry predicted from the loaded edges and the phase target
localparam int CLOSE_STEPS = obstacle_pkg::CLOSE_IN_TARGET - (obstacle_pkg::FIELD_TOP + 1);
localparam int EXP_TOP     = obstacle_pkg::CLOSE_IN_TARGET;
localparam int EXP_LEFT    = obstacle_pkg::FIELD_LEFT + 1 + CLOSE_STEPS;
localparam int EXP_BOTTOM  = obstacle_pkg::FIELD_BOTTOM - 1 - CLOSE_STEPS;

// one pixel in, result checked after the painter register
task automatic probe_pixel(input int x, input int y, input bit wall);
    obstacle_pkg::rgb_t colour;
    colour = obstacle_pkg::rgb_t'($urandom);
    @(posedge clk);
    hcount <= obstacle_pkg::coord_t'(x);
    vcount <= obstacle_pkg::coord_t'(y);
    rgb_in <= colour;
    @(posedge clk);
    @(negedge clk);
    check_eq("rgb_out", rgb_out, wall ? obstacle_pkg::WALL_RGB : colour);
    check_eq("obstacle_x", obstacle_x, wall ? x : 0);
    check_eq("obstacle_y", obstacle_y, wall ? y : 0);
endtask

task automatic start_run(input logic [2:0] sel, input logic play);
    @(posedge clk);
    selected      <= sel;
    play_selected <= play;
    done_in       <= 1'b1;
    @(posedge clk);
    done_in <= 1'b0;    // single-cycle strobe
endtask

// holds the pixel and watches every cycle until it turns into wall
task automatic wait_for_wall(input int x, input int y);
    int n;
    bit hit;
    hit = 1'b0;
    n   = 0;
    @(posedge clk);
    hcount <= obstacle_pkg::coord_t'(x);
    vcount <= obstacle_pkg::coord_t'(y);
    rgb_in <= obstacle_pkg::rgb_t'($urandom);
    @(posedge clk);
    while (!hit && n < WALL_TIMEOUT) begin
        @(negedge clk);
        if (rgb_out == obstacle_pkg::WALL_RGB && obstacle_x == x && obstacle_y == y)
            hit = 1'b1;
        else
            @(posedge clk);
        n++;
    end
    assert (hit)
    else stop_on_error($sformatf("timeout: pixel %0d,%0d never became wall", x, y));
endtask

task automatic wait_done();
    int n;
    bit seen;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < DONE_TIMEOUT) begin
        @(negedge clk);
        seen = done;
        n++;
    end
    assert (seen) else stop_on_error("timeout: done did not pulse at the end of the program");
endtask

task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        assert (!done) else stop_on_error("done pulsed although no run was in progress");
    end
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

task automatic check_reset_state();
    check_eq("rgb_out", rgb_out, 0);
    check_eq("obstacle_x", obstacle_x, 0);
    check_eq("obstacle_y", obstacle_y, 0);
    check_eq("done", done, 0);
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b0);
    probe_pixel(CENTRE_X, CENTRE_Y, 1'b0);
    probe_pixel(100, 50, 1'b0);
endtask

task automatic ignore_bad_starts();
    start_run(3'd5, 1'b1);                      // wrong menu code
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b0);
    probe_pixel(obstacle_pkg::FIELD_RIGHT, obstacle_pkg::FIELD_BOTTOM, 1'b0);
    start_run(SELECT_CODE, 1'b0);               // play not selected
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_BOTTOM, 1'b0);
    probe_pixel(obstacle_pkg::FIELD_RIGHT, obstacle_pkg::FIELD_TOP, 1'b0);
    @(posedge clk);
    play_selected <= 1'b1;
    selected      <= SELECT_CODE;
    expect_quiet(DONE_TIMEOUT);
endtask

task automatic full_program_run();
    int count_before;
    count_before = done_count;
    start_run(SELECT_CODE, 1'b1);
    // first probe lands before the first step, edges still at border +-1
    probe_pixel(obstacle_pkg::FIELD_LEFT + 2, obstacle_pkg::FIELD_TOP + 2, 1'b0);
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b1);
    probe_pixel(CENTRE_X, CENTRE_Y, 1'b0);
    probe_pixel(100, 100, 1'b0);

    wait_for_wall(obstacle_pkg::FIELD_LEFT + 50, obstacle_pkg::FIELD_TOP + 50);
    probe_pixel(CENTRE_X, CENTRE_Y, 1'b0);

    // top edge reaches its target, the dwell plus one step period keeps
    // the close-in hole in place for the next three probes
    wait_for_wall(CENTRE_X, EXP_TOP);
    probe_pixel(EXP_LEFT + 1, EXP_BOTTOM - 1, 1'b0);
    probe_pixel(EXP_LEFT + 1, EXP_TOP + 1, 1'b0);
    probe_pixel(EXP_LEFT, CENTRE_Y, 1'b1);

    wait_done();
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_eq("done_count", done_count - count_before, 1);
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b0);
    probe_pixel(CENTRE_X, CENTRE_Y, 1'b0);
endtask

task automatic abort_on_menu();
    int count_before;
    count_before = done_count;
    start_run(SELECT_CODE, 1'b1);
    wait_for_wall(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP);
    @(posedge clk);
    menu_on <= 1'b1;
    @(posedge clk);
    menu_on <= 1'b0;
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b0);
    expect_quiet(DONE_TIMEOUT);
    check_eq("done_count", done_count - count_before, 0);
endtask

task automatic restart_after_run();
    int count_before;
    count_before = done_count;
    start_run(SELECT_CODE, 1'b1);
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b1);
    wait_done();
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_eq("done_count", done_count - count_before, 1);
    probe_pixel(obstacle_pkg::FIELD_LEFT, obstacle_pkg::FIELD_TOP, 1'b0);
endtask

//--- dv/square_hole_obstacle_tb.sv
`timescale 1ns/1ns

module square_hole_obstacle_tb;

    localparam logic [2:0]  SELECT_CODE  = 3'd3;
    localparam logic [25:0] MOVE_TICKS   = 26'd2;
    localparam logic [25:0] DWELL_TICKS  = 26'd3;
    localparam int          DONE_TIMEOUT = 20000;   // cycles
    localparam int          WALL_TIMEOUT = 2000;    // cycles

    logic                 clk;
    logic                 rst;
    obstacle_pkg::coord_t hcount;
    obstacle_pkg::coord_t vcount;
    obstacle_pkg::rgb_t   rgb_in;
    logic                 menu_on;
    logic                 play_selected;
    logic [2:0]           selected;
    logic                 done_in;
    obstacle_pkg::rgb_t   rgb_out;
    obstacle_pkg::coord_t obstacle_x;
    obstacle_pkg::coord_t obstacle_y;
    logic                 done;

    int done_count;     // done strobes seen since reset

    square_hole_obstacle #(
        .SELECT_CODE (SELECT_CODE),
        .MOVE_TICKS  (MOVE_TICKS),
        .DWELL_TICKS (DWELL_TICKS)
    ) u_square_hole_obstacle (
        .clk           (clk),
        .rst           (rst),
        .hcount        (hcount),
        .vcount        (vcount),
        .rgb_in        (rgb_in),
        .menu_on       (menu_on),
        .play_selected (play_selected),
        .selected      (selected),
        .done_in       (done_in),
        .rgb_out       (rgb_out),
        .obstacle_x    (obstacle_x),
        .obstacle_y    (obstacle_y),
        .done          (done)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        if (!rst && done)
            done_count <= done_count + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // error reporting and value checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp)
        else stop_on_error($sformatf("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                                     $time, name, got, exp));
    endtask

    `include "obstacle_tests.svh"

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h6206));
        done_count    = 0;
        clk           = 1'b0;
        rst           = 1'b1;
        hcount        = '0;
        vcount        = '0;
        rgb_in        = '0;
        menu_on       = 1'b0;
        play_selected = 1'b1;
        selected      = SELECT_CODE;
        done_in       = 1'b0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        check_reset_state();
        ignore_bad_starts();
        full_program_run();
        abort_on_menu();
        restart_after_run();

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+dv
design/obstacle_pkg.sv
design/hole_sequencer.sv
design/hole_edge_mover.sv
design/wall_painter.sv
design/square_hole_obstacle.sv
dv/square_hole_obstacle_tb.sv
